// File: sb_pkg.sv
/* scoreboard shared definitions */

package sb_pkg;

  // ---------------------------------------------------------------------------
  // sizes
  // ---------------------------------------------------------------------------
  // slot count, must stay a power of two so the pointers wrap for free
  localparam int unsigned NR_ENTRIES      = 8;
  localparam int unsigned TRANS_ID_BITS   = $clog2(NR_ENTRIES);
  // commit stage may retire this many slots per cycle
  localparam int unsigned NR_COMMIT_PORTS = 2;
  // integer register file
  localparam int unsigned REG_ADDR_BITS   = 5;
  localparam int unsigned NR_REGS         = 2 ** REG_ADDR_BITS;
  localparam int unsigned XLEN            = 32;

  // ---------------------------------------------------------------------------
  // types
  // ---------------------------------------------------------------------------
  // slot index, doubles as the transaction ID handed to the issue stage
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]          xlen_t;

  // number of commits in one cycle, 0 up to NR_COMMIT_PORTS
  typedef logic [$clog2(NR_COMMIT_PORTS+1)-1:0] commit_cnt_t;

  // functional unit that produces the result of a slot
  // FU_NONE needs no write-back and completes by itself
  typedef enum logic [2:0] {
    FU_NONE  = 3'd0,
    FU_ALU   = 3'd1,
    FU_LOAD  = 3'd2,
    FU_STORE = 3'd3,
    FU_MULT  = 3'd4,
    FU_CSR   = 3'd5
  } fu_e;

endpackage

// File: sb_ctrl.sv
/* scoreboard queue control */

module sb_ctrl (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  input  logic                                         flush_unissued_i,
  input  logic                                         unresolved_branch_i,
  input  logic                                         decoded_valid_i,
  input  logic                                         issue_ack_i,
  input  logic [sb_pkg::NR_COMMIT_PORTS-1:0]           commit_ack_i,
  output logic                                         issue_valid_o,
  output logic                                         decoded_ack_o,
  output logic                                         sb_full_o,
  output logic                                         issue_en_o,
  output sb_pkg::trans_id_t                            issue_ptr_o,
  output sb_pkg::trans_id_t [sb_pkg::NR_COMMIT_PORTS-1:0] commit_ptr_o
);

  import sb_pkg::*;

  // occupancy never exceeds NR_ENTRIES-1, so a slot index is wide enough
  trans_id_t   cnt_q, cnt_d;
  trans_id_t   issue_ptr_q, issue_ptr_d;
  trans_id_t   commit_ptr_q, commit_ptr_d;
  commit_cnt_t num_commit;

  // one slot is kept free, full at NR_ENTRIES-1
  assign sb_full_o = (cnt_q == trans_id_t'(NR_ENTRIES - 1));

  // ---------------------------------------------------------------------------
  // issue handshake
  // ---------------------------------------------------------------------------
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~sb_full_o;
  assign decoded_ack_o = issue_ack_i & ~sb_full_o;
  // write into the slot unless the unissued part of the pipe is flushed
  assign issue_en_o    = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  // count the acks from the commit stage
  always_comb begin
    num_commit = '0;
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      num_commit = num_commit + commit_cnt_t'(commit_ack_i[k]);
    end
  end

  // ---------------------------------------------------------------------------
  // pointers and count
  // ---------------------------------------------------------------------------
  always_comb begin
    cnt_d        = cnt_q + trans_id_t'(issue_en_o) - trans_id_t'(num_commit);
    issue_ptr_d  = issue_ptr_q + trans_id_t'(issue_en_o);
    commit_ptr_d = commit_ptr_q + trans_id_t'(num_commit);
    // flush drops everything in flight
    if (flush_i) begin
      cnt_d        = '0;
      issue_ptr_d  = '0;
      commit_ptr_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
    end else begin
      cnt_q        <= cnt_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
    end
  end

  assign issue_ptr_o = issue_ptr_q;

  // commit port k looks k slots past the oldest one, wraps with the index width
  always_comb begin
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      commit_ptr_o[k] = commit_ptr_q + trans_id_t'(k);
    end
  end

endmodule

// File: sb_entry_array.sv
/* scoreboard slot storage */

module sb_entry_array (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  // issue write
  input  logic                                            issue_en_i,
  input  sb_pkg::trans_id_t                               issue_ptr_i,
  input  sb_pkg::fu_e                                     decoded_fu_i,
  input  sb_pkg::reg_addr_t                               decoded_rd_i,
  // write-back
  input  logic                                            wb_valid_i,
  input  sb_pkg::trans_id_t                               wb_trans_id_i,
  input  sb_pkg::xlen_t                                   wb_data_i,
  // commit
  input  logic [sb_pkg::NR_COMMIT_PORTS-1:0]              commit_ack_i,
  input  sb_pkg::trans_id_t [sb_pkg::NR_COMMIT_PORTS-1:0] commit_ptr_i,
  // slot contents
  output logic [sb_pkg::NR_ENTRIES-1:0]                   slot_busy_o,
  output logic [sb_pkg::NR_ENTRIES-1:0]                   slot_done_o,
  output sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]            slot_fu_o,
  output sb_pkg::reg_addr_t [sb_pkg::NR_ENTRIES-1:0]      slot_rd_o,
  output sb_pkg::xlen_t [sb_pkg::NR_ENTRIES-1:0]          slot_result_o
);

  import sb_pkg::*;

  // busy: slot holds an issued instruction
  // done: its result is available
  logic [NR_ENTRIES-1:0]      busy_q, busy_d;
  logic [NR_ENTRIES-1:0]      done_q, done_d;
  fu_e [NR_ENTRIES-1:0]       fu_q, fu_d;
  reg_addr_t [NR_ENTRIES-1:0] rd_q, rd_d;
  xlen_t [NR_ENTRIES-1:0]     result_q, result_d;

  // later updates in this block override earlier ones
  always_comb begin
    busy_d   = busy_q;
    done_d   = done_q;
    fu_d     = fu_q;
    rd_d     = rd_q;
    result_d = result_q;

    // -------------------------------------------------------------------------
    // issue write
    // -------------------------------------------------------------------------
    if (issue_en_i) begin
      busy_d[issue_ptr_i] = 1'b1;
      done_d[issue_ptr_i] = 1'b0;
      fu_d[issue_ptr_i]   = decoded_fu_i;
      rd_d[issue_ptr_i]   = decoded_rd_i;
    end

    // nothing to wait for, complete one edge after being stored
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (busy_q[i] && fu_q[i] == FU_NONE) begin
        done_d[i] = 1'b1;
      end
    end

    // -------------------------------------------------------------------------
    // write-back
    // -------------------------------------------------------------------------
    // results for empty slots are stale, e.g. a unit still busy after a flush
    if (wb_valid_i && busy_q[wb_trans_id_i]) begin
      done_d[wb_trans_id_i]   = 1'b1;
      result_d[wb_trans_id_i] = wb_data_i;
    end

    // retire the acked slots
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        busy_d[commit_ptr_i[k]] = 1'b0;
        done_d[commit_ptr_i[k]] = 1'b0;
      end
    end

    if (flush_i) begin
      busy_d = '0;
      done_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
      done_q <= '0;
    end else begin
      busy_q <= busy_d;
      done_q <= done_d;
    end
  end

  // slot payload, only looked at while busy
  always_ff @(posedge clk_i) begin
    fu_q     <= fu_d;
    rd_q     <= rd_d;
    result_q <= result_d;
  end

  assign slot_busy_o   = busy_q;
  assign slot_done_o   = done_q;
  assign slot_fu_o     = fu_q;
  assign slot_rd_o     = rd_q;
  assign slot_result_o = result_q;

endmodule

// File: sb_clobber.sv
/* register clobber map */

module sb_clobber (
  input  logic [sb_pkg::NR_ENTRIES-1:0]              slot_busy_i,
  input  sb_pkg::fu_e [sb_pkg::NR_ENTRIES-1:0]       slot_fu_i,
  input  sb_pkg::reg_addr_t [sb_pkg::NR_ENTRIES-1:0] slot_rd_i,
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]          rd_clobber_o
);

  import sb_pkg::*;

  // per register, the unit that is going to write it
  // fixed priority, walking down so the lowest slot index is applied last
  always_comb begin
    for (int unsigned r = 0; r < NR_REGS; r++) begin
      rd_clobber_o[r] = FU_NONE;
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (slot_busy_i[i] && slot_rd_i[i] == reg_addr_t'(r)) begin
          rd_clobber_o[r] = slot_fu_i[i];
        end
      end
    end
    // x0 is hardwired, never waits on anyone
    rd_clobber_o[0] = FU_NONE;
  end

endmodule

// File: sb_operand_fwd.sv
/* operand forwarding for rs1 and rs2 */

module sb_operand_fwd (
  input  sb_pkg::reg_addr_t                          rs1_i,
  input  sb_pkg::reg_addr_t                          rs2_i,
  // write-back port, forwarded in the same cycle
  input  logic                                       wb_valid_i,
  input  sb_pkg::trans_id_t                          wb_trans_id_i,
  input  sb_pkg::xlen_t                              wb_data_i,
  // slot contents
  input  logic [sb_pkg::NR_ENTRIES-1:0]              slot_busy_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0]              slot_done_i,
  input  sb_pkg::reg_addr_t [sb_pkg::NR_ENTRIES-1:0] slot_rd_i,
  input  sb_pkg::xlen_t [sb_pkg::NR_ENTRIES-1:0]     slot_result_i,
  output sb_pkg::xlen_t                              rs1_o,
  output sb_pkg::xlen_t                              rs2_o,
  output logic                                       rs1_valid_o,
  output logic                                       rs2_valid_o
);

  import sb_pkg::*;

  // both read ports share one selection loop, index 0 is rs1
  reg_addr_t [1:0] rs_addr;
  xlen_t [1:0]     rs_data;
  logic [1:0]      rs_hit;
  logic            wb_live;

  assign rs_addr = {rs2_i, rs1_i};

  // write-back only counts when it lands in an occupied slot
  assign wb_live = wb_valid_i & slot_busy_i[wb_trans_id_i];

  // ---------------------------------------------------------------------------
  // fixed-priority select
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int unsigned p = 0; p < 2; p++) begin
      rs_hit[p]  = 1'b0;
      rs_data[p] = '0;
      // finished slots, lowest index wins
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (slot_busy_i[i] && slot_done_i[i] && slot_rd_i[i] == rs_addr[p]) begin
          rs_hit[p]  = 1'b1;
          rs_data[p] = slot_result_i[i];
        end
      end
      // result arriving this cycle beats anything already stored
      if (wb_live && slot_rd_i[wb_trans_id_i] == rs_addr[p]) begin
        rs_hit[p]  = 1'b1;
        rs_data[p] = wb_data_i;
      end
    end
  end

  assign rs1_o = rs_data[0];
  assign rs2_o = rs_data[1];

  // x0 comes from the register file, never forwarded
  assign rs1_valid_o = rs_hit[0] & (|rs1_i);
  assign rs2_valid_o = rs_hit[1] & (|rs2_i);

endmodule

// File: scoreboard.sv
/* instruction scoreboard top level */

module scoreboard (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             flush_i,
  input  logic                                             flush_unissued_i,
  input  logic                                             unresolved_branch_i,
  // decode and issue
  input  logic                                             decoded_valid_i,
  input  sb_pkg::fu_e                                      decoded_fu_i,
  input  sb_pkg::reg_addr_t                                decoded_rd_i,
  input  logic                                             issue_ack_i,
  output logic                                             sb_full_o,
  output logic                                             issue_valid_o,
  output logic                                             decoded_ack_o,
  output sb_pkg::trans_id_t                                issue_trans_id_o,
  // write-back
  input  logic                                             wb_valid_i,
  input  sb_pkg::trans_id_t                                wb_trans_id_i,
  input  sb_pkg::xlen_t                                    wb_data_i,
  // commit
  input  logic [sb_pkg::NR_COMMIT_PORTS-1:0]               commit_ack_i,
  output logic [sb_pkg::NR_COMMIT_PORTS-1:0]               commit_valid_o,
  output sb_pkg::fu_e [sb_pkg::NR_COMMIT_PORTS-1:0]        commit_fu_o,
  output sb_pkg::reg_addr_t [sb_pkg::NR_COMMIT_PORTS-1:0]  commit_rd_o,
  output sb_pkg::xlen_t [sb_pkg::NR_COMMIT_PORTS-1:0]      commit_result_o,
  output sb_pkg::trans_id_t [sb_pkg::NR_COMMIT_PORTS-1:0]  commit_trans_id_o,
  // clobber map and operand read
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]                rd_clobber_o,
  input  sb_pkg::reg_addr_t                                rs1_i,
  output sb_pkg::xlen_t                                    rs1_o,
  output logic                                             rs1_valid_o,
  input  sb_pkg::reg_addr_t                                rs2_i,
  output sb_pkg::xlen_t                                    rs2_o,
  output logic                                             rs2_valid_o
);

  import sb_pkg::*;

  logic                             issue_en;
  trans_id_t                        issue_ptr;
  trans_id_t [NR_COMMIT_PORTS-1:0]  commit_ptr;
  logic [NR_ENTRIES-1:0]            slot_busy;
  logic [NR_ENTRIES-1:0]            slot_done;
  fu_e [NR_ENTRIES-1:0]             slot_fu;
  reg_addr_t [NR_ENTRIES-1:0]       slot_rd;
  xlen_t [NR_ENTRIES-1:0]           slot_result;

  sb_ctrl i_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .flush_unissued_i    (flush_unissued_i),
    .unresolved_branch_i (unresolved_branch_i),
    .decoded_valid_i     (decoded_valid_i),
    .issue_ack_i         (issue_ack_i),
    .commit_ack_i        (commit_ack_i),
    .issue_valid_o       (issue_valid_o),
    .decoded_ack_o       (decoded_ack_o),
    .sb_full_o           (sb_full_o),
    .issue_en_o          (issue_en),
    .issue_ptr_o         (issue_ptr),
    .commit_ptr_o        (commit_ptr)
  );

  sb_entry_array i_entry_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_en_i    (issue_en),
    .issue_ptr_i   (issue_ptr),
    .decoded_fu_i  (decoded_fu_i),
    .decoded_rd_i  (decoded_rd_i),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .commit_ack_i  (commit_ack_i),
    .commit_ptr_i  (commit_ptr),
    .slot_busy_o   (slot_busy),
    .slot_done_o   (slot_done),
    .slot_fu_o     (slot_fu),
    .slot_rd_o     (slot_rd),
    .slot_result_o (slot_result)
  );

  sb_clobber i_clobber (
    .slot_busy_i  (slot_busy),
    .slot_fu_i    (slot_fu),
    .slot_rd_i    (slot_rd),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .slot_busy_i   (slot_busy),
    .slot_done_i   (slot_done),
    .slot_rd_i     (slot_rd),
    .slot_result_i (slot_result),
    .rs1_o         (rs1_o),
    .rs2_o         (rs2_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_valid_o   (rs2_valid_o)
  );

  assign issue_trans_id_o = issue_ptr;

  // commit view, the oldest slots read straight out of the array
  // done is only ever set on a busy slot, so it alone marks a finished one
  for (genvar k = 0; k < NR_COMMIT_PORTS; k++) begin : gen_commit
    assign commit_valid_o[k]    = slot_done[commit_ptr[k]];
    assign commit_fu_o[k]       = slot_fu[commit_ptr[k]];
    assign commit_rd_o[k]       = slot_rd[commit_ptr[k]];
    assign commit_result_o[k]   = slot_result[commit_ptr[k]];
    assign commit_trans_id_o[k] = commit_ptr[k];
  end

endmodule

// File: tb_scoreboard.sv
/* scoreboard testbench */

module tb_scoreboard;

  timeunit 1ns;
  timeprecision 100ps;

  import sb_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;

  // one row per cycle
  // creq is what the commit stage would like to retire, gated by the model
  // ctl packs {flush, flush_unissued, unresolved_branch}
  typedef struct packed {
    logic       dv;
    fu_e        fu;
    reg_addr_t  rd;
    logic       ack;
    logic       wbv;
    trans_id_t  wbid;
    logic [1:0] creq;
    logic [2:0] ctl;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
  } row_t;

  logic clk_i;
  logic rst_ni;
  logic flush_i;
  logic flush_unissued_i;
  logic unresolved_branch_i;
  logic decoded_valid_i;
  fu_e decoded_fu_i;
  reg_addr_t decoded_rd_i;
  logic issue_ack_i;
  logic wb_valid_i;
  trans_id_t wb_trans_id_i;
  xlen_t wb_data_i;
  logic [NR_COMMIT_PORTS-1:0] commit_ack_i;
  reg_addr_t rs1_i;
  reg_addr_t rs2_i;
  logic sb_full_o;
  logic issue_valid_o;
  logic decoded_ack_o;
  trans_id_t issue_trans_id_o;
  logic [NR_COMMIT_PORTS-1:0] commit_valid_o;
  fu_e [NR_COMMIT_PORTS-1:0] commit_fu_o;
  reg_addr_t [NR_COMMIT_PORTS-1:0] commit_rd_o;
  xlen_t [NR_COMMIT_PORTS-1:0] commit_result_o;
  trans_id_t [NR_COMMIT_PORTS-1:0] commit_trans_id_o;
  fu_e [NR_REGS-1:0] rd_clobber_o;
  xlen_t rs1_o;
  xlen_t rs2_o;
  logic rs1_valid_o;
  logic rs2_valid_o;

  row_t  rows[$];
  row_t  cur;
  xlen_t cur_wb_data;
  logic [1:0] cur_ack;
  logic  table_ready;
  logic [31:0] lcg_state;
  int err_data;
  int err_fu;
  int err_id;
  int err_reg;
  int err_bit;

  // reference model state mirrors the slots after each edge
  logic [NR_ENTRIES-1:0] m_busy;
  logic [NR_ENTRIES-1:0] m_done;
  fu_e       m_fu  [NR_ENTRIES];
  reg_addr_t m_rd  [NR_ENTRIES];
  xlen_t     m_res [NR_ENTRIES];
  trans_id_t m_cnt;
  trans_id_t m_iptr;
  trans_id_t m_cptr;

  scoreboard i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------------
  // check tasks
  // ---------------------------------------------------------------------------
  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_data++;
    end
  endtask

  task automatic check_fu(input string name, input fu_e got, input fu_e exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_fu++;
    end
  endtask

  task automatic check_id(input string name, input trans_id_t got, input trans_id_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_id++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_reg++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      err_bit++;
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic void add_row(input logic dv, input fu_e fu, input reg_addr_t rd,
                                  input logic ack, input logic wbv, input trans_id_t wbid,
                                  input logic [1:0] creq, input logic [2:0] ctl,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
    row_t r;
    r = '{dv, fu, rd, ack, wbv, wbid, creq, ctl, rs1, rs2};
    rows.push_back(r);
  endfunction

  // ---------------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------------
  task automatic model_reset();
    m_busy = '0;
    m_done = '0;
    m_cnt  = '0;
    m_iptr = '0;
    m_cptr = '0;
    for (int i = 0; i < NR_ENTRIES; i++) begin
      m_fu[i]  = FU_NONE;
      m_rd[i]  = '0;
      m_res[i] = '0;
    end
  endtask

  // port 1 retires only along with port 0, and only finished slots
  function automatic logic [1:0] gate_commit(input logic [1:0] req);
    logic [1:0] ack;
    trans_id_t  second;
    second = m_cptr + trans_id_t'(1);
    ack[0] = req[0] & m_busy[m_cptr] & m_done[m_cptr];
    ack[1] = req[1] & ack[0] & m_busy[second] & m_done[second];
    return ack;
  endfunction

  // first occupied slot in index order names the writer
  function automatic fu_e expected_clobber(input int r);
    fu_e  fu;
    logic found;
    fu    = FU_NONE;
    found = 1'b0;
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (!found && m_busy[i] && m_rd[i] == reg_addr_t'(r)) begin
        fu    = m_fu[i];
        found = 1'b1;
      end
    end
    return (r == 0) ? FU_NONE : fu;
  endfunction

  // known is low when the source slot never received a result
  task automatic expect_operand(input reg_addr_t rs, output xlen_t data, output logic valid,
                                output logic known);
    logic found;
    data  = '0;
    valid = 1'b0;
    known = 1'b0;
    found = 1'b0;
    if (cur.wbv && m_busy[cur.wbid] && m_rd[cur.wbid] == rs) begin
      data  = cur_wb_data;
      valid = 1'b1;
      known = 1'b1;
      found = 1'b1;
    end
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (!found && m_busy[i] && m_done[i] && m_rd[i] == rs) begin
        data  = m_res[i];
        valid = 1'b1;
        known = (m_fu[i] != FU_NONE);
        found = 1'b1;
      end
    end
    if (rs == '0) valid = 1'b0;
  endtask

  // state after the coming edge
  task automatic model_step();
    logic [NR_ENTRIES-1:0] busy_n;
    logic [NR_ENTRIES-1:0] done_n;
    logic      write;
    trans_id_t ncommit;
    trans_id_t idx;
    write   = cur.dv & cur.ack & (m_cnt != trans_id_t'(NR_ENTRIES - 1)) & ~cur.ctl[1];
    busy_n  = m_busy;
    done_n  = m_done;
    ncommit = '0;
    if (write) begin
      busy_n[m_iptr] = 1'b1;
      done_n[m_iptr] = 1'b0;
      m_fu[m_iptr]   = cur.fu;
      m_rd[m_iptr]   = cur.rd;
    end
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (m_busy[i] && m_fu[i] == FU_NONE) done_n[i] = 1'b1;
    end
    if (cur.wbv && m_busy[cur.wbid]) begin
      done_n[cur.wbid] = 1'b1;
      m_res[cur.wbid]  = cur_wb_data;
    end
    for (int k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (cur_ack[k]) begin
        idx         = m_cptr + trans_id_t'(k);
        busy_n[idx] = 1'b0;
        done_n[idx] = 1'b0;
        ncommit++;
      end
    end
    m_cnt  = m_cnt + trans_id_t'(write) - ncommit;
    m_iptr = m_iptr + trans_id_t'(write);
    m_cptr = m_cptr + ncommit;
    m_busy = busy_n;
    m_done = done_n;
    if (cur.ctl[2]) begin
      m_busy = '0;
      m_done = '0;
      m_cnt  = '0;
      m_iptr = '0;
      m_cptr = '0;
    end
  endtask

  task automatic check_outputs();
    logic      full;
    trans_id_t idx;
    xlen_t     data;
    logic      valid;
    logic      known;
    full = (m_cnt == trans_id_t'(NR_ENTRIES - 1));
    check_bit("sb_full_o", sb_full_o, full);
    check_bit("issue_valid_o", issue_valid_o, cur.dv & ~cur.ctl[0] & ~full);
    check_bit("decoded_ack_o", decoded_ack_o, cur.ack & ~full);
    check_id("issue_trans_id_o", issue_trans_id_o, m_iptr);
    for (int k = 0; k < NR_COMMIT_PORTS; k++) begin
      idx = m_cptr + trans_id_t'(k);
      check_bit($sformatf("commit_valid_o[%0d]", k), commit_valid_o[k],
                m_busy[idx] & m_done[idx]);
      check_id($sformatf("commit_trans_id_o[%0d]", k), commit_trans_id_o[k], idx);
      if (m_busy[idx] && m_done[idx]) begin
        check_fu($sformatf("commit_fu_o[%0d]", k), commit_fu_o[k], m_fu[idx]);
        check_reg($sformatf("commit_rd_o[%0d]", k), commit_rd_o[k], m_rd[idx]);
        if (m_fu[idx] != FU_NONE) begin
          check_data($sformatf("commit_result_o[%0d]", k), commit_result_o[k], m_res[idx]);
        end
      end
    end
    for (int r = 0; r < NR_REGS; r++) begin
      check_fu($sformatf("rd_clobber_o[%0d]", r), rd_clobber_o[r], expected_clobber(r));
    end
    expect_operand(cur.rs1, data, valid, known);
    check_bit("rs1_valid_o", rs1_valid_o, valid);
    if (valid && known) check_data("rs1_o", rs1_o, data);
    expect_operand(cur.rs2, data, valid, known);
    check_bit("rs2_valid_o", rs2_valid_o, valid);
    if (valid && known) check_data("rs2_o", rs2_o, data);
  endtask

  // ---------------------------------------------------------------------------
  // stimulus table
  // ---------------------------------------------------------------------------
  task automatic build_table();
    // dv, fu, rd, ack, wbv, wbid, creq, ctl, rs1, rs2
    // branch holds issue back, then fill up to full
    add_row(1'b1, FU_ALU,   5'd5,  1'b0, 1'b0, 3'd0, 2'b00, 3'b001, 5'd0,  5'd0);
    add_row(1'b1, FU_ALU,   5'd5,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_LOAD,  5'd5,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_NONE,  5'd0,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_MULT,  5'd7,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_NONE,  5'd8,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_CSR,   5'd9,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_ALU,   5'd3,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    // queue full and slot 3 not done yet
    add_row(1'b1, FU_STORE, 5'd4,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd8,  5'd7);
    add_row(1'b1, FU_STORE, 5'd4,  1'b1, 1'b1, 3'd0, 2'b11, 3'b000, 5'd5,  5'd0);
    // write-back beats the finished slot 0
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd1, 2'b11, 3'b000, 5'd5,  5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b0, 3'd0, 2'b11, 3'b000, 5'd5,  5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd3, 2'b11, 3'b000, 5'd0,  5'd7);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd5, 2'b11, 3'b000, 5'd0,  5'd0);
    // refill across the wrap with a dual commit of slots 7 and 0
    // slot 7 writes x0 through a real unit
    add_row(1'b1, FU_ALU,   5'd0,  1'b1, 1'b0, 3'd0, 2'b11, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_MULT,  5'd11, 1'b1, 1'b1, 3'd6, 2'b11, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_CSR,   5'd12, 1'b1, 1'b1, 3'd7, 2'b01, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_ALU,   5'd12, 1'b1, 1'b1, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd1, 2'b11, 3'b000, 5'd12, 5'd11);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd2, 2'b11, 3'b000, 5'd12, 5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b0, 3'd0, 2'b11, 3'b000, 5'd12, 5'd0);
    // unissued flush then a full flush with a late write-back
    add_row(1'b1, FU_LOAD,  5'd14, 1'b1, 1'b0, 3'd0, 2'b00, 3'b010, 5'd0,  5'd0);
    add_row(1'b1, FU_LOAD,  5'd14, 1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b1, FU_ALU,   5'd15, 1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd14, 5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd3, 2'b00, 3'b100, 5'd14, 5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd4, 2'b00, 3'b000, 5'd15, 5'd0);
    add_row(1'b1, FU_ALU,   5'd1,  1'b1, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b1, 3'd0, 2'b11, 3'b000, 5'd1,  5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b0, 3'd0, 2'b11, 3'b000, 5'd1,  5'd0);
    add_row(1'b0, FU_NONE,  5'd0,  1'b0, 1'b0, 3'd0, 2'b00, 3'b000, 5'd0,  5'd0);
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial begin
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    flush_unissued_i    = 1'b0;
    unresolved_branch_i = 1'b0;
    decoded_valid_i     = 1'b0;
    decoded_fu_i        = FU_NONE;
    decoded_rd_i        = '0;
    issue_ack_i         = 1'b0;
    wb_valid_i          = 1'b0;
    wb_trans_id_i       = '0;
    wb_data_i           = '0;
    commit_ack_i        = '0;
    rs1_i               = '0;
    rs2_i               = '0;
    cur                 = '0;
    cur_ack             = '0;
    cur_wb_data         = '0;
    lcg_state           = 32'd43;
    err_data            = 0;
    err_fu              = 0;
    err_id              = 0;
    err_reg             = 0;
    err_bit             = 0;
    table_ready         = 1'b0;
    build_table();
    table_ready = 1'b1;
    model_reset();

    // look at the idle outputs while reset is still held
    repeat (RESET_CYCLES - 1) @(posedge clk_i);
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int n = 0; n < rows.size(); n++) begin
      @(posedge clk_i);
      cur         = rows[n];
      cur_wb_data = lcg_next();
      cur_ack     = gate_commit(cur.creq);
      decoded_valid_i     <= cur.dv;
      decoded_fu_i        <= cur.fu;
      decoded_rd_i        <= cur.rd;
      issue_ack_i         <= cur.ack;
      wb_valid_i          <= cur.wbv;
      wb_trans_id_i       <= cur.wbid;
      wb_data_i           <= cur_wb_data;
      commit_ack_i        <= cur_ack;
      flush_i             <= cur.ctl[2];
      flush_unissued_i    <= cur.ctl[1];
      unresolved_branch_i <= cur.ctl[0];
      rs1_i               <= cur.rs1;
      rs2_i               <= cur.rs2;
      // outputs are settled half a cycle later
      @(negedge clk_i);
      check_outputs();
      model_step();
    end

    $display("errors: data %0d, fu %0d, id %0d, rd %0d, bit %0d",
             err_data, err_fu, err_id, err_reg, err_bit);
    if (err_data + err_fu + err_id + err_reg + err_bit == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog allows twice the expected run length
  initial begin
    wait (table_ready);
    #((rows.size() + 20) * CLK_PERIOD * 2);
    $display("watchdog expired before the stimulus table was done");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: all.f
sb_pkg.sv
sb_ctrl.sv
sb_entry_array.sv
sb_clobber.sv
sb_operand_fwd.sv
scoreboard.sv
tb_scoreboard.sv

// File: run_sim.sh
#!/bin/sh
# build the scoreboard testbench with Verilator and run it
# passes only when the pass message shows up in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_scoreboard -f all.f -o sim_scoreboard \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_scoreboard)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
